// ==== common/arcade_input_pkg.sv ====
// Shared types and constants for the arcade player input front end
// Key codes, host word bit positions and the packed control structs

package arcade_input_pkg;

    ////////////////////
    // Host keyboard event
    ////////////////////
    typedef struct packed {
        logic       toggle;    // Flips once per new event
        logic       pressed;   // 1 on make, 0 on break
        logic       extended;
        logic [7:0] code;
    } ps2_key_t;

    // Held keyboard buttons, active high
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic start1;
        logic start2;
        logic coin;
        logic pause;
        logic test;
        logic fire1;
        logic fire2;
    } key_btn_t;

    // One player as seen by the game, active low
    typedef struct packed {
        logic jump;
        logic fire;
        logic up;
        logic down;
        logic left;
        logic right;
    } player_ctl_t;

    // Cabinet start and coin lines, active low
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
    } sys_ctl_t;

    // HDMI aspect ratio numerator and denominator
    typedef struct packed {
        logic [7:0] arx;
        logic [7:0] ary;
    } aspect_t;

    ////////////////////
    // Joystick word bits
    ////////////////////
    localparam int JOY_RIGHT  = 0;
    localparam int JOY_LEFT   = 1;
    localparam int JOY_DOWN   = 2;
    localparam int JOY_UP     = 3;
    localparam int JOY_FIRE   = 4;
    localparam int JOY_JUMP   = 5;
    localparam int JOY_START1 = 6;
    localparam int JOY_START2 = 7;
    localparam int JOY_COIN   = 8;
    localparam int JOY_PAUSE  = 9;

    // OSD status word bits
    localparam int ST_RESET = 0;
    localparam int ST_WIDE  = 1;
    localparam int ST_HORZ  = 2;
    localparam int ST_FLIP  = 11;

    ////////////////////
    // Scan codes, set 2
    ////////////////////
    localparam logic [7:0] KEY_UP    = 8'h75;
    localparam logic [7:0] KEY_DOWN  = 8'h72;
    localparam logic [7:0] KEY_LEFT  = 8'h6B;
    localparam logic [7:0] KEY_RIGHT = 8'h74;
    localparam logic [7:0] KEY_F1    = 8'h05;
    localparam logic [7:0] KEY_F2    = 8'h06;
    localparam logic [7:0] KEY_F3    = 8'h04;
    localparam logic [7:0] KEY_F4    = 8'h0C;
    localparam logic [7:0] KEY_F5    = 8'h03;
    localparam logic [7:0] KEY_CTRL  = 8'h14;
    localparam logic [7:0] KEY_ALT   = 8'h11;
    localparam logic [7:0] KEY_SPACE = 8'h29;

endpackage

// ==== ps2_decode/ps2_key_decode.sv ====
// Keyboard event decoder
// Turns toggle-marked scan events into held button levels

module ps2_key_decode
    import arcade_input_pkg::*;
(
    input  logic     clk_sys,
    input  logic     arst_n,
    input  ps2_key_t ps2_key,
    output key_btn_t key_btn
);

    // Toggle bit as seen at the previous edge
    logic toggle_q;
    logic key_event;

    // New event whenever the toggle moved
    assign key_event = ps2_key.toggle != toggle_q;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            toggle_q <= 1'b0;
        end else begin
            toggle_q <= ps2_key.toggle;
        end
    end

    ////////////////////
    // Key map
    ////////////////////
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            key_btn <= '0;
        end else if (key_event) begin
            // Extended flag ignored, arrows match either way
            case (ps2_key.code)
                // Directions
                KEY_UP: begin
                    key_btn.up <= ps2_key.pressed;
                end
                KEY_DOWN: begin
                    key_btn.down <= ps2_key.pressed;
                end
                KEY_LEFT: begin
                    key_btn.left <= ps2_key.pressed;
                end
                KEY_RIGHT: begin
                    key_btn.right <= ps2_key.pressed;
                end
                // Function row
                KEY_F1: begin
                    key_btn.start1 <= ps2_key.pressed;
                end
                KEY_F2: begin
                    key_btn.start2 <= ps2_key.pressed;
                end
                KEY_F3: begin
                    key_btn.coin <= ps2_key.pressed;
                end
                KEY_F4: begin
                    key_btn.pause <= ps2_key.pressed;
                end
                KEY_F5: begin
                    key_btn.test <= ps2_key.pressed;
                end
                // Ctrl and alt share the main fire button
                KEY_CTRL, KEY_ALT: begin
                    key_btn.fire1 <= ps2_key.pressed;
                end
                KEY_SPACE: begin
                    key_btn.fire2 <= ps2_key.pressed;
                end
                default: begin
                    // Unmapped key, hold everything
                end
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    // Each event moves at most one button and only after a toggle flip
    a_btn_needs_event : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        $changed(key_btn) |-> $changed(toggle_q) && $onehot0(key_btn ^ $past(key_btn))
    );

endmodule

// ==== verilog/control_merge.sv ====
// Keyboard and joystick merge for both players
// Registers the active-low controls and keeps the pause toggle

module control_merge
    import arcade_input_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n,
    input  key_btn_t    key_btn,
    input  logic [15:0] joy_0,
    input  logic [15:0] joy_1,
    input  logic        status_rst,
    input  logic        osd_rst,
    output player_ctl_t p1,
    output player_ctl_t p2,
    output sys_ctl_t    sys,
    output logic        run_en
);

    // Merged pause, active high, and its previous value
    logic pause_lvl;
    logic pause_prev;
    logic pause_rise;
    logic force_run;

    // Active-low player word from a joystick word
    // Keyboard bits ORed in only where use_key is set
    function automatic player_ctl_t merge_player(
        input key_btn_t    kb,
        input logic [15:0] joy,
        input logic        use_key
    );
        player_ctl_t ctl;
        ctl.jump  = ~((use_key & kb.fire2) | joy[JOY_JUMP]);
        ctl.fire  = ~((use_key & kb.fire1) | joy[JOY_FIRE]);
        ctl.up    = ~((use_key & kb.up)    | joy[JOY_UP]);
        ctl.down  = ~((use_key & kb.down)  | joy[JOY_DOWN]);
        ctl.left  = ~((use_key & kb.left)  | joy[JOY_LEFT]);
        ctl.right = ~((use_key & kb.right) | joy[JOY_RIGHT]);
        return ctl;
    endfunction

    ////////////////////
    // Player and cabinet lines
    ////////////////////
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            p1  <= '1;
            p2  <= '1;
            sys <= '1;
        end else begin
            p1 <= merge_player(key_btn, joy_0, 1'b1);
            // Second player has no keyboard
            p2 <= merge_player(key_btn, joy_1, 1'b0);
            sys.start[0] <= ~(key_btn.start1 | joy_0[JOY_START1]);
            sys.start[1] <= ~(key_btn.start2 | joy_0[JOY_START2]);
            sys.coin[0]  <= ~(key_btn.coin   | joy_0[JOY_COIN]);
            // Second coin slot not wired
            sys.coin[1]  <= 1'b1;
        end
    end

    ////////////////////
    // Pause toggle
    ////////////////////
    assign pause_rise = pause_lvl & ~pause_prev;
    assign force_run  = status_rst | osd_rst;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            pause_lvl  <= 1'b0;
            pause_prev <= 1'b0;
            run_en     <= 1'b1;
        end else begin
            pause_lvl  <= key_btn.pause | joy_0[JOY_PAUSE];
            pause_prev <= pause_lvl;
            // Reset request wins over a press in the same cycle
            if (force_run) begin
                run_en <= 1'b1;
            end else if (pause_rise) begin
                run_en <= ~run_en;
            end
        end
    end

    // Game run state moves only after a reset request or a rise of the held pause
    a_run_en_cause : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        $changed(run_en) |-> $past(force_run) || $rose(pause_prev)
    );

endmodule

// ==== verilog/port_drive.sv ====
// Game side port registers and OSD status decode
// Drives player ports, aspect ratio, rotation, flip and the user LED

module port_drive
    import arcade_input_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n,
    input  player_ctl_t p1,
    input  player_ctl_t p2,
    input  sys_ctl_t    sys,
    input  logic [31:0] status,
    input  logic        downloading,
    output player_ctl_t p1_port,
    output player_ctl_t p2_port,
    output sys_ctl_t    sys_port,
    output aspect_t     aspect,
    output logic [1:0]  rotate,
    output logic        flip,
    output logic        led_user
);

    // Next aspect from the OSD bits
    aspect_t aspect_d;

    always_comb begin
        if (status[ST_WIDE]) begin
            aspect_d = '{arx: 8'd16, ary: 8'd9};
        end else if (status[ST_HORZ]) begin
            aspect_d = '{arx: 8'd4, ary: 8'd3};
        end else begin
            // Native vertical monitor
            aspect_d = '{arx: 8'd3, ary: 8'd4};
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            p1_port  <= '1;
            p2_port  <= '1;
            sys_port <= '1;
            aspect   <= '{arx: 8'd3, ary: 8'd4};
            rotate   <= 2'b01;
            flip     <= 1'b0;
            led_user <= 1'b0;
        end else begin
            p1_port  <= p1;
            p2_port  <= p2;
            sys_port <= sys;
            aspect   <= aspect_d;
            // Low bit fixed, screen is always rotated
            rotate   <= {status[ST_FLIP], 1'b1};
            flip     <= status[ST_FLIP];
            led_user <= downloading;
        end
    end

endmodule

// ==== verilog/arcade_input_top.sv ====
// Player input and configuration front end
// Key decode, control merge and port drive in series

module arcade_input_top
    import arcade_input_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n,
    input  ps2_key_t    ps2_key,
    input  logic [15:0] joy_0,
    input  logic [15:0] joy_1,
    input  logic [31:0] status,
    input  logic [1:0]  buttons,
    input  logic        downloading,
    output player_ctl_t p1_port,
    output player_ctl_t p2_port,
    output sys_ctl_t    sys_port,
    output logic        run_en,
    output aspect_t     aspect,
    output logic [1:0]  rotate,
    output logic        flip,
    output logic        led_user
);

    key_btn_t    key_btn;
    player_ctl_t p1;
    player_ctl_t p2;
    sys_ctl_t    sys;

    ////////////////////
    // Decode
    ////////////////////
    ps2_key_decode u_decode (
        .clk_sys ( clk_sys ),
        .arst_n  ( arst_n  ),
        .ps2_key ( ps2_key ),
        .key_btn ( key_btn )
    );

    // Merge, reset requests from OSD status and the OSD button
    control_merge u_merge (
        .clk_sys    ( clk_sys          ),
        .arst_n     ( arst_n           ),
        .key_btn    ( key_btn          ),
        .joy_0      ( joy_0            ),
        .joy_1      ( joy_1            ),
        .status_rst ( status[ST_RESET] ),
        .osd_rst    ( buttons[1]       ),
        .p1         ( p1               ),
        .p2         ( p2               ),
        .sys        ( sys              ),
        .run_en     ( run_en           )
    );

    // Result
    port_drive u_drive (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .p1          ( p1          ),
        .p2          ( p2          ),
        .sys         ( sys         ),
        .status      ( status      ),
        .downloading ( downloading ),
        .p1_port     ( p1_port     ),
        .p2_port     ( p2_port     ),
        .sys_port    ( sys_port    ),
        .aspect      ( aspect      ),
        .rotate      ( rotate      ),
        .flip        ( flip        ),
        .led_user    ( led_user    )
    );

endmodule

// ==== verif/arcade_input_checker.sv ====
// Checker for the arcade input front end
// Cycle model of key map, merge, pause and status decode, compared every cycle

module arcade_input_checker
    import arcade_input_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n,
    input  ps2_key_t    ps2_key,
    input  logic [15:0] joy_0,
    input  logic [15:0] joy_1,
    input  logic [31:0] status,
    input  logic [1:0]  buttons,
    input  logic        downloading,
    input  player_ctl_t p1_port,
    input  player_ctl_t p2_port,
    input  sys_ctl_t    sys_port,
    input  logic        run_en,
    input  aspect_t     aspect,
    input  logic [1:0]  rotate,
    input  logic        flip,
    input  logic        led_user,
    input  int          test_id,
    input  logic        done,
    output int          err_total,
    output int          check_total
);

    localparam int NUM_TESTS = 6;

    // Merged controls one stage ahead of the ports
    typedef struct packed {
        player_ctl_t p1;
        player_ctl_t p2;
        sys_ctl_t    sys;
        logic        pause;
    } merged_t;

    typedef struct packed {
        aspect_t    aspect;
        logic [1:0] rotate;
        logic       flip;
    } config_t;

    ////////////////////
    // Model state
    ////////////////////
    // Values as expected after the latest edge
    logic     tog_q;
    key_btn_t kb;
    merged_t  mrg;
    merged_t  port;
    logic     pause_prev;
    logic     run_exp;
    config_t  cfg;
    logic     led_exp;
    logic     force_run;
    logic     rise;

    int   checks_by_test [NUM_TESTS];
    int   errs_by_test [NUM_TESTS];
    int   cur_id;
    logic reported;

    // Key map, one button per code, unknown codes change nothing
    function automatic key_btn_t key_map(input key_btn_t b, input ps2_key_t k);
        key_btn_t n;
        n = b;
        case (k.code)
            KEY_UP:            n.up     = k.pressed;
            KEY_DOWN:          n.down   = k.pressed;
            KEY_LEFT:          n.left   = k.pressed;
            KEY_RIGHT:         n.right  = k.pressed;
            KEY_F1:            n.start1 = k.pressed;
            KEY_F2:            n.start2 = k.pressed;
            KEY_F3:            n.coin   = k.pressed;
            KEY_F4:            n.pause  = k.pressed;
            KEY_F5:            n.test   = k.pressed;
            KEY_CTRL, KEY_ALT: n.fire1  = k.pressed;
            KEY_SPACE:         n.fire2  = k.pressed;
            default:           n = b;
        endcase
        return n;
    endfunction

    // Reference merge, low when keyboard or joystick is high
    function automatic merged_t merge_ref(
        input key_btn_t    b,
        input logic [15:0] j0,
        input logic [15:0] j1
    );
        merged_t m;
        m.p1.jump     = ~(b.fire2 | j0[JOY_JUMP]);
        m.p1.fire     = ~(b.fire1 | j0[JOY_FIRE]);
        m.p1.up       = ~(b.up    | j0[JOY_UP]);
        m.p1.down     = ~(b.down  | j0[JOY_DOWN]);
        m.p1.left     = ~(b.left  | j0[JOY_LEFT]);
        m.p1.right    = ~(b.right | j0[JOY_RIGHT]);
        // Player 2 joystick only
        m.p2.jump     = ~j1[JOY_JUMP];
        m.p2.fire     = ~j1[JOY_FIRE];
        m.p2.up       = ~j1[JOY_UP];
        m.p2.down     = ~j1[JOY_DOWN];
        m.p2.left     = ~j1[JOY_LEFT];
        m.p2.right    = ~j1[JOY_RIGHT];
        m.sys.start   = ~{b.start2 | j0[JOY_START2], b.start1 | j0[JOY_START1]};
        m.sys.coin    = {1'b1, ~(b.coin | j0[JOY_COIN])};
        m.pause       = b.pause | j0[JOY_PAUSE];
        return m;
    endfunction

    // Aspect priority wide, then horizontal, else vertical
    function automatic config_t config_ref(input logic [31:0] st);
        config_t c;
        if (st[ST_WIDE]) begin
            c.aspect = '{arx: 8'd16, ary: 8'd9};
        end else if (st[ST_HORZ]) begin
            c.aspect = '{arx: 8'd4, ary: 8'd3};
        end else begin
            c.aspect = '{arx: 8'd3, ary: 8'd4};
        end
        c.rotate = {st[ST_FLIP], 1'b1};
        c.flip   = st[ST_FLIP];
        return c;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset";
            1:       return "key_map";
            2:       return "ignored_events";
            3:       return "joystick_merge";
            4:       return "pause_toggle";
            5:       return "status_decode";
            default: return "unknown";
        endcase
    endfunction

    task automatic reset_model();
        tog_q      = 1'b0;
        kb         = '0;
        mrg        = '1;
        mrg.pause  = 1'b0;
        port       = mrg;
        pause_prev = 1'b0;
        run_exp    = 1'b1;
        cfg        = '{aspect: '{arx: 8'd3, ary: 8'd4}, rotate: 2'b01, flip: 1'b0};
        led_exp    = 1'b0;
    endtask

    task automatic check_value(
        input string       sig,
        input logic [31:0] exp_val,
        input logic [31:0] act_val
    );
        checks_by_test[test_id]++;
        check_total++;
        if (act_val !== exp_val) begin
            errs_by_test[test_id]++;
            err_total++;
            $display("** Error %s: %s expected %h actual %h at %0t",
                     test_name(test_id), sig, exp_val, act_val, $time);
        end
    endtask

    task automatic report_test(input int id);
        $display("Test %s: %0d checks, %0d errors",
                 test_name(id), checks_by_test[id], errs_by_test[id]);
    endtask

    initial begin
        reset_model();
        for (int i = 0; i < NUM_TESTS; i++) begin
            checks_by_test[i] = 0;
            errs_by_test[i]   = 0;
        end
        cur_id      = 0;
        reported    = 1'b0;
        err_total   = 0;
        check_total = 0;
    end

    ////////////////////
    // Model update
    ////////////////////
    // Inputs are stable at the edge, old model values used first
    always @(posedge clk_sys) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            force_run  = status[ST_RESET] | buttons[1];
            rise       = mrg.pause & ~pause_prev;
            port       = mrg;
            pause_prev = mrg.pause;
            mrg        = merge_ref(kb, joy_0, joy_1);
            if (ps2_key.toggle != tog_q) begin
                kb = key_map(kb, ps2_key);
            end
            tog_q = ps2_key.toggle;
            // Reset request beats a toggle
            if (force_run) begin
                run_exp = 1'b1;
            end else if (rise) begin
                run_exp = ~run_exp;
            end
            cfg     = config_ref(status);
            led_exp = downloading;
        end
        // Per test lines and the closing count
        if (done && !reported) begin
            report_test(cur_id);
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     NUM_TESTS, check_total, err_total);
            reported = 1'b1;
        end else if (!done && test_id != cur_id) begin
            report_test(cur_id);
            cur_id = test_id;
        end
    end

    ////////////////////
    // Compare
    ////////////////////
    // Mid cycle, DUT outputs settled
    always @(negedge clk_sys) begin
        check_value("p1_port", port.p1, p1_port);
        check_value("p2_port", port.p2, p2_port);
        check_value("sys_port", port.sys, sys_port);
        check_value("run_en", run_exp, run_en);
        check_value("aspect", cfg.aspect, aspect);
        check_value("rotate", cfg.rotate, rotate);
        check_value("flip", cfg.flip, flip);
        check_value("led_user", led_exp, led_user);
    end

endmodule

// ==== verif/arcade_input_tb.sv ====
// Testbench for the arcade player input front end
// Clock, reset, scripted and random stimulus, watchdog

module arcade_input_tb
    import arcade_input_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    // Cycle budget of each test
    localparam int RESET_CYCLES  = 14;
    localparam int KEY_CYCLES    = 120;
    localparam int IGNORE_CYCLES = 54;
    localparam int JOY_CYCLES    = 76;
    localparam int PAUSE_CYCLES  = 72;
    localparam int CFG_CYCLES    = 48;
    localparam int RUN_CYCLES    = RESET_CYCLES + KEY_CYCLES + IGNORE_CYCLES
                                 + JOY_CYCLES + PAUSE_CYCLES + CFG_CYCLES;
    localparam int MARGIN_CYCLES = 50;

    logic        clk_sys;
    logic        arst_n;
    ps2_key_t    ps2_key;
    logic [15:0] joy_0;
    logic [15:0] joy_1;
    logic [31:0] status;
    logic [1:0]  buttons;
    logic        downloading;
    player_ctl_t p1_port;
    player_ctl_t p2_port;
    sys_ctl_t    sys_port;
    logic        run_en;
    aspect_t     aspect;
    logic [1:0]  rotate;
    logic        flip;
    logic        led_user;

    int          test_id;
    logic        done;
    int          err_total;
    int          check_total;
    logic [31:0] rng_state;
    logic [7:0]  key_codes [12];

    arcade_input_top dut (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .ps2_key     ( ps2_key     ),
        .joy_0       ( joy_0       ),
        .joy_1       ( joy_1       ),
        .status      ( status      ),
        .buttons     ( buttons     ),
        .downloading ( downloading ),
        .p1_port     ( p1_port     ),
        .p2_port     ( p2_port     ),
        .sys_port    ( sys_port    ),
        .run_en      ( run_en      ),
        .aspect      ( aspect      ),
        .rotate      ( rotate      ),
        .flip        ( flip        ),
        .led_user    ( led_user    )
    );

    arcade_input_checker u_checker (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .ps2_key     ( ps2_key     ),
        .joy_0       ( joy_0       ),
        .joy_1       ( joy_1       ),
        .status      ( status      ),
        .buttons     ( buttons     ),
        .downloading ( downloading ),
        .p1_port     ( p1_port     ),
        .p2_port     ( p2_port     ),
        .sys_port    ( sys_port    ),
        .run_en      ( run_en      ),
        .aspect      ( aspect      ),
        .rotate      ( rotate      ),
        .flip        ( flip        ),
        .led_user    ( led_user    ),
        .test_id     ( test_id     ),
        .done        ( done        ),
        .err_total   ( err_total   ),
        .check_total ( check_total )
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // Inputs move 5 units after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_sys);
        #5;
    endtask

    // New host event, marked by a toggle flip
    task automatic send_key(input logic [7:0] code, input logic pressed);
        ps2_key = '{toggle: ~ps2_key.toggle, pressed: pressed, extended: 1'b0, code: code};
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        logic [31:0] r;
        clk_sys     = 1'b0;
        arst_n      = 1'b0;
        ps2_key     = '0;
        joy_0       = '0;
        joy_1       = '0;
        status      = '0;
        buttons     = '0;
        downloading = 1'b0;
        test_id     = 0;
        done        = 1'b0;
        rng_state   = 32'h41f5_dfc6;
        key_codes   = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_F1, KEY_F2,
                        KEY_F3, KEY_F4, KEY_F5, KEY_CTRL, KEY_ALT, KEY_SPACE};

        // Reset held for 10 cycles, then idle
        repeat (10) @(posedge clk_sys);
        #5;
        arst_n = 1'b1;
        wait_cycles(4);

        // Make and break of every mapped key
        test_id = 1;
        for (int i = 0; i < 12; i++) begin
            send_key(key_codes[i], 1'b1);
            wait_cycles(5);
            send_key(key_codes[i], 1'b0);
            wait_cycles(5);
        end

        test_id = 2;
        // Left held so a stray clear reaches the port
        send_key(KEY_LEFT, 1'b1);
        wait_cycles(3);
        // Mapped codes with bit 7 set are unknown keys
        for (int i = 0; i < 8; i++) begin
            next_rand(r);
            send_key({1'b1, key_codes[r[7:0] % 12][6:0]}, r[8]);
            wait_cycles(3);
        end
        send_key(KEY_LEFT, 1'b0);
        wait_cycles(3);
        // Mapped codes with the toggle left alone
        for (int i = 0; i < 8; i++) begin
            ps2_key.code    = key_codes[i];
            ps2_key.pressed = 1'b1;
            wait_cycles(3);
        end

        // Random joysticks with a few random keys on top
        test_id = 3;
        for (int i = 0; i < 64; i++) begin
            next_rand(r);
            joy_0 = r[15:0];
            joy_1 = r[31:16];
            if (i % 4 == 0) begin
                next_rand(r);
                send_key(key_codes[r[7:0] % 12], r[8]);
            end
            wait_cycles(1);
        end
        joy_0 = '0;
        joy_1 = '0;
        for (int i = 0; i < 12; i++) begin
            send_key(key_codes[i], 1'b0);
            wait_cycles(1);
        end

        // Pause from keyboard and joystick
        test_id = 4;
        for (int i = 0; i < 2; i++) begin
            send_key(KEY_F4, 1'b1);
            wait_cycles(4);
            send_key(KEY_F4, 1'b0);
            wait_cycles(4);
            joy_0[JOY_PAUSE] = 1'b1;
            wait_cycles(4);
            joy_0[JOY_PAUSE] = 1'b0;
            wait_cycles(4);
        end
        // Long hold gives one toggle
        joy_0[JOY_PAUSE] = 1'b1;
        wait_cycles(12);
        joy_0[JOY_PAUSE] = 1'b0;
        wait_cycles(4);
        // Status reset against a press in flight
        send_key(KEY_F4, 1'b1);
        status[ST_RESET] = 1'b1;
        wait_cycles(4);
        status[ST_RESET] = 1'b0;
        send_key(KEY_F4, 1'b0);
        wait_cycles(4);
        joy_0[JOY_PAUSE] = 1'b1;
        wait_cycles(4);
        // OSD reset button
        buttons[1] = 1'b1;
        wait_cycles(4);
        buttons[1] = 1'b0;
        joy_0[JOY_PAUSE] = 1'b0;
        wait_cycles(8);

        // All wide, horizontal and flip combinations
        test_id = 5;
        for (int c = 0; c < 8; c++) begin
            for (int d = 0; d < 2; d++) begin
                status           = '0;
                status[ST_WIDE]  = c[0];
                status[ST_HORZ]  = c[1];
                status[ST_FLIP]  = c[2];
                downloading      = d[0];
                wait_cycles(3);
            end
        end

        done = 1'b1;
        @(posedge clk_sys);
        #1;
        if (err_total == 0 && check_total > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////
    initial begin
        #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish within %0d cycles",
                 RUN_CYCLES + MARGIN_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== arcade_input.f ====
common/arcade_input_pkg.sv
ps2_decode/ps2_key_decode.sv
verilog/control_merge.sv
verilog/port_drive.sv
verilog/arcade_input_top.sv
verif/arcade_input_checker.sv
verif/arcade_input_tb.sv

// ==== Bender.yml ====
package:
  name: arcade_input

sources:
  - common/arcade_input_pkg.sv
  - ps2_decode/ps2_key_decode.sv
  - verilog/control_merge.sv
  - verilog/port_drive.sv
  - verilog/arcade_input_top.sv
  - target: test
    files:
      - verif/arcade_input_checker.sv
      - verif/arcade_input_tb.sv
